//--- noun_eq.f
+incdir+verilog
verilog/noun_eq_pkg.sv
verilog/node_mem_if.sv
verilog/noun_store.sv
verilog/pair_stack.sv
verilog/visit_counter.sv
verilog/eq_fsm.sv
verilog/apb_regs.sv
verilog/noun_eq_top.sv
tb/tb_clk_gen.sv
tb/noun_eq_asserts.sv
tb/tb_noun_eq.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f noun_eq.f --top-module tb_noun_eq \
  -o tb_noun_eq > sim.log 2>&1 &&
./obj_dir/tb_noun_eq >> sim.log 2>&1 ||
echo "Verification failed" >> sim.log
cat sim.log
if grep -q "Verification failed" sim.log; then exit 1; fi
exit 0

//--- tb/noun_eq_asserts.sv
`timescale 1ns/1ps

module noun_eq_asserts (
  input logic                  clk,
  input logic                  rst,
  input logic                  busy,
  input logic                  done,
  input noun_eq_pkg::verdict_e verdict,
  input logic                  push,
  input logic                  pop
);

  // Running and finished are exclusive
  busy_done_excl: assert property (@(posedge clk) disable iff (!rst) !(busy && done))
    else $error("busy and done are high in the same cycle");

  // Verdict is cleared at start and only set on the way to DONE
  verdict_clear_busy: assert property (@(posedge clk) disable iff (!rst)
    busy |-> (verdict == noun_eq_pkg::V_NONE))
    else $error("verdict is not V_NONE while the engine is busy");

  // Stack is either pushed or popped in a cycle
  push_pop_excl: assert property (@(posedge clk) disable iff (!rst) !(push && pop))
    else $error("push and pop are high in the same cycle");

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held low for four cycles, released on a falling edge
  initial begin
    rst = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
  end

endmodule

//--- tb/tb_noun_eq.sv
`timescale 1ns/1ps
`include "noun_eq_params.svh"

module tb_noun_eq;

  localparam int POLL_LIMIT = 3000;

  logic                    clk;
  logic                    rst;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`NOUN_APB_AW-1:0] paddr;
  logic [31:0]             pwdata;
  logic [31:0]             prdata;
  logic                    pready;
  logic                    pslverr;

  // Testbench copy of the node store
  noun_eq_pkg::noun_word_t model_mem [`NOUN_DEPTH];
  logic [7:0]              free_q [$];
  int                      model_visits;
  int                      errors;
  int                      errs_at_start;
  int                      tests_run;
  int                      tests_failed;
  string                   cur_test;

  tb_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  noun_eq_top UUT (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  bind eq_fsm noun_eq_asserts u_fsm_asserts (
    .clk     (clk),
    .rst     (rst),
    .busy    (busy),
    .done    (done),
    .verdict (verdict),
    .push    (push),
    .pop     (pop)
  );

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    errs_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errs_at_start) begin
      $display("%s: ok", cur_test);
    end else begin
      $display("%s: FAILED", cur_test);
      tests_failed++;
    end
  endtask

  // Setup phase on one falling edge, access phase on the next
  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #5;
    err = pslverr;
    check_value("pready", 32'd1, {31'd0, pready});
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #5;
    data = prdata;
    err  = pslverr;
    check_value("pready", 32'd1, {31'd0, pready});
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic noun_eq_pkg::noun_word_t make_node(input logic ht, input logic tt,
                                                       input logic [7:0] h, input logic [7:0] t);
    noun_eq_pkg::noun_word_t w;
    w.hed_tag = ht;
    w.tel_tag = tt;
    w.hed     = h;
    w.tel     = t;
    return w;
  endfunction

  // Lockstep walk, hed before tel, pending tel pairs on a 16-entry stack
  function automatic logic [1:0] model_compare(input logic [7:0] ra, input logic [7:0] rb);
    noun_eq_pkg::noun_word_t na;
    noun_eq_pkg::noun_word_t nb;
    logic [7:0]              ca;
    logic [7:0]              cb;
    logic [7:0]              stk_a [$];
    logic [7:0]              stk_b [$];
    logic [1:0]              result;
    logic                    finished;
    ca = ra;
    cb = rb;
    finished = 1'b0;
    result = noun_eq_pkg::V_NONE;
    model_visits = 0;
    while (!finished) begin
      finished = 1'b1;
      na = model_mem[ca];
      nb = model_mem[cb];
      if (model_visits == `NOUN_VISIT_LIMIT) begin
        result = noun_eq_pkg::V_ABORT;
      end else begin
        model_visits++;
        if (na.hed_tag != nb.hed_tag || na.tel_tag != nb.tel_tag) begin
          result = noun_eq_pkg::V_NOT_EQUAL;
        end else if ((!na.hed_tag && na.hed != nb.hed) || (!na.tel_tag && na.tel != nb.tel)) begin
          result = noun_eq_pkg::V_NOT_EQUAL;
        end else if (na.hed_tag && na.tel_tag) begin
          if (stk_a.size() == `NOUN_STACK_DEPTH) begin
            result = noun_eq_pkg::V_ABORT;
          end else begin
            stk_a.push_back(na.tel);
            stk_b.push_back(nb.tel);
            ca = na.hed;
            cb = nb.hed;
            finished = 1'b0;
          end
        end else if (na.hed_tag || na.tel_tag) begin
          ca = na.hed_tag ? na.hed : na.tel;
          cb = nb.hed_tag ? nb.hed : nb.tel;
          finished = 1'b0;
        end else if (stk_a.size() == 0) begin
          result = noun_eq_pkg::V_EQUAL;
        end else begin
          ca = stk_a.pop_back();
          cb = stk_b.pop_back();
          finished = 1'b0;
        end
      end
    end
    return result;
  endfunction

  task automatic take_free(output logic [7:0] a);
    int pick;
    pick = int'($urandom_range(free_q.size() - 1, 0));
    a = free_q[pick];
    free_q.delete(pick);
  endtask

  // Random tree built bottom up, leftover subtrees joined under cells
  task automatic build_tree(input logic [7:0] base, output logic [7:0] root, output int count);
    noun_eq_pkg::noun_word_t w;
    logic [7:0]              idx;
    logic [7:0]              a;
    int                      n_init;
    idx = base;
    n_init = int'($urandom_range(20, 4));
    free_q.delete();
    for (int i = 0; i < n_init; i++) begin
      w = make_node(1'b0, 1'b0, 8'($urandom_range(255, 0)), 8'($urandom_range(255, 0)));
      if (free_q.size() > 0 && $urandom_range(1, 0) == 1) begin
        take_free(a);
        w.hed_tag = 1'b1;
        w.hed     = a;
      end
      if (free_q.size() > 0 && $urandom_range(1, 0) == 1) begin
        take_free(a);
        w.tel_tag = 1'b1;
        w.tel     = a;
      end
      model_mem[idx] = w;
      free_q.push_back(idx);
      idx = idx + 8'd1;
    end
    while (free_q.size() > 1) begin
      w = make_node(1'b1, 1'b1, 8'd0, 8'd0);
      take_free(a);
      w.hed = a;
      take_free(a);
      w.tel = a;
      model_mem[idx] = w;
      free_q.push_back(idx);
      idx = idx + 8'd1;
    end
    root  = free_q[0];
    count = int'(idx - base);
  endtask

  task automatic copy_tree(input logic [7:0] src, input logic [7:0] dst, input int count);
    noun_eq_pkg::noun_word_t w;
    for (int i = 0; i < count; i++) begin
      w = model_mem[src + 8'(i)];
      if (w.hed_tag) w.hed = w.hed + (dst - src);
      if (w.tel_tag) w.tel = w.tel + (dst - src);
      model_mem[dst + 8'(i)] = w;
    end
  endtask

  // One tag flip or one atom change on a random node of the copy
  task automatic mutate_node(input logic [7:0] base, input int count);
    noun_eq_pkg::noun_word_t w;
    logic [7:0]              k;
    logic                    flip_tag;
    k = base + 8'($urandom_range(count - 1, 0));
    w = model_mem[k];
    flip_tag = 1'($urandom_range(1, 0));
    if ($urandom_range(1, 0) == 0) begin
      if (flip_tag || w.hed_tag) w.hed_tag = ~w.hed_tag;
      else w.hed = w.hed ^ 8'($urandom_range(255, 1));
    end else begin
      if (flip_tag || w.tel_tag) w.tel_tag = ~w.tel_tag;
      else w.tel = w.tel ^ 8'($urandom_range(255, 1));
    end
    model_mem[k] = w;
  endtask

  task automatic load_nodes(input logic [7:0] lo, input int count);
    logic [11:0] addr;
    logic        err;
    for (int i = 0; i < count; i++) begin
      addr = 12'(`NOUN_NODE_BASE + 4 * (int'(lo) + i));
      apb_write(addr, {14'd0, model_mem[lo + 8'(i)]}, err);
      check_value("node load pslverr", 32'd0, {31'd0, err});
    end
  endtask

  task automatic start_run(input logic [7:0] ra, input logic [7:0] rb);
    logic err;
    apb_write(`NOUN_REG_ROOTS, {16'd0, rb, ra}, err);
    check_value("roots write pslverr", 32'd0, {31'd0, err});
    apb_write(`NOUN_REG_CTRL, 32'd1, err);
    check_value("start write pslverr", 32'd0, {31'd0, err});
  endtask

  task automatic finish_run(input logic [1:0] exp_v);
    logic [31:0] st;
    logic        err;
    int          polls;
    polls = 0;
    st = '0;
    while (!st[1] && polls < POLL_LIMIT) begin
      apb_read(`NOUN_REG_STATUS, st, err);
      polls++;
    end
    if (!st[1]) begin
      $display("Timeout: the engine never reported done in %s", cur_test);
      errors++;
    end else begin
      check_value("status", {28'd0, exp_v, 2'b10}, st);
      apb_read(`NOUN_REG_VISITS, st, err);
      check_value("visits", 32'(model_visits), st);
    end
  endtask

  task automatic run_case(input logic [7:0] ra, input logic [7:0] rb);
    logic [1:0] exp_v;
    exp_v = model_compare(ra, rb);
    start_run(ra, rb);
    finish_run(exp_v);
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] st0;
    logic        err;
    logic [7:0]  root;
    logic [1:0]  exp_v;
    int          count;
    int          wait_cnt;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    void'($urandom(32'h27eb_5369));
    for (int i = 0; i < `NOUN_DEPTH; i++) model_mem[i] = '0;

    wait_cnt = 0;
    while (!rst && wait_cnt < 20) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!rst) begin
      $display("Reset was never released");
      errors++;
    end else begin
      begin_test("reset_status");
      apb_read(`NOUN_REG_STATUS, rd, err);
      check_value("status after reset", 32'd0, rd);
      apb_read(`NOUN_REG_VISITS, rd, err);
      check_value("visits after reset", 32'd0, rd);
      end_test();

      for (int t = 0; t < 12; t++) begin
        begin_test($sformatf("equal_random_%0d", t));
        build_tree(8'd0, root, count);
        copy_tree(8'd0, 8'd64, count);
        load_nodes(8'd0, count);
        load_nodes(8'd64, count);
        check_value("model verdict", 32'(noun_eq_pkg::V_EQUAL),
                    32'(model_compare(root, root + 8'd64)));
        run_case(root, root + 8'd64);
        end_test();
      end

      for (int t = 0; t < 12; t++) begin
        begin_test($sformatf("not_equal_random_%0d", t));
        build_tree(8'd0, root, count);
        copy_tree(8'd0, 8'd64, count);
        mutate_node(8'd64, count);
        load_nodes(8'd0, count);
        load_nodes(8'd64, count);
        check_value("model verdict", 32'(noun_eq_pkg::V_NOT_EQUAL),
                    32'(model_compare(root, root + 8'd64)));
        run_case(root, root + 8'd64);
        end_test();
      end

      begin_test("same_root");
      build_tree(8'd0, root, count);
      load_nodes(8'd0, count);
      check_value("model verdict", 32'(noun_eq_pkg::V_EQUAL),
                  32'(model_compare(root, root)));
      run_case(root, root);
      end_test();

      // Chain of cell pairs deeper than the stack, plus two self loops
      for (int j = 0; j < 20; j++) begin
        model_mem[128 + j] = make_node(1'b1, 1'b1, 8'(129 + j), 8'd200);
      end
      model_mem[148] = make_node(1'b0, 1'b0, 8'h11, 8'h22);
      model_mem[200] = make_node(1'b0, 1'b0, 8'h33, 8'h44);
      model_mem[210] = make_node(1'b0, 1'b1, 8'h5a, 8'd210);
      model_mem[211] = make_node(1'b1, 1'b1, 8'd211, 8'd211);
      load_nodes(8'd128, 21);
      load_nodes(8'd200, 1);
      load_nodes(8'd210, 2);

      begin_test("cyclic_visit_limit");
      run_case(8'd210, 8'd210);
      end_test();

      begin_test("cyclic_stack_overflow");
      run_case(8'd211, 8'd211);
      end_test();

      begin_test("deep_chain_overflow");
      run_case(8'd128, 8'd128);
      end_test();

      // The loop runs long enough to hit it with writes while busy
      begin_test("busy_write_rejected");
      exp_v = model_compare(8'd210, 8'd210);
      start_run(8'd210, 8'd210);
      apb_write(12'(`NOUN_NODE_BASE + 4 * 210), 32'd0, err);
      check_value("node write while busy pslverr", 32'd1, {31'd0, err});
      apb_write(`NOUN_REG_ROOTS, 32'd0, err);
      check_value("roots write while busy pslverr", 32'd1, {31'd0, err});
      finish_run(exp_v);
      apb_read(`NOUN_REG_ROOTS, rd, err);
      check_value("roots kept", {16'd0, 8'd210, 8'd210}, rd);
      end_test();

      begin_test("unmapped_access");
      apb_read(`NOUN_REG_STATUS, st0, err);
      apb_read(12'h010, rd, err);
      check_value("unmapped read pslverr", 32'd1, {31'd0, err});
      apb_write(12'h014, 32'd1, err);
      check_value("unmapped write pslverr", 32'd1, {31'd0, err});
      apb_write(12'h402, 32'd0, err);
      check_value("misaligned node write pslverr", 32'd1, {31'd0, err});
      apb_write(12'h800, 32'd0, err);
      check_value("write past node window pslverr", 32'd1, {31'd0, err});
      apb_read(`NOUN_REG_STATUS, rd, err);
      check_value("status unchanged", st0, rd);
      end_test();
    end

    $display("Tests: %0d run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- verilog/apb_regs.sv
`timescale 1ns/1ps
`include "noun_eq_params.svh"

module apb_regs (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [`NOUN_APB_AW-1:0]                paddr,
  input  logic [31:0]                            pwdata,
  output logic [31:0]                            prdata,
  output logic                                   pready,
  output logic                                   pslverr,
  node_mem_if.host                               mem,
  output logic                                   start,
  output logic [`NOUN_FIELD_W-1:0]               root_a,
  output logic [`NOUN_FIELD_W-1:0]               root_b,
  input  logic                                   busy,
  input  logic                                   done,
  input  noun_eq_pkg::verdict_e                  verdict,
  input  logic [$clog2(`NOUN_VISIT_LIMIT+1)-1:0] visits
);

  localparam int VW = $clog2(`NOUN_VISIT_LIMIT + 1);

  logic                    access;
  logic                    wr_access;
  logic                    is_ctrl;
  logic                    is_roots;
  logic                    is_status;
  logic                    is_visits;
  logic                    in_window;
  logic [`NOUN_APB_AW-1:0] node_off;

  assign access    = psel && penable;
  assign wr_access = access && pwrite;
  assign pready    = 1'b1;

  // Address decode
  assign is_ctrl   = (paddr == `NOUN_REG_CTRL);
  assign is_roots  = (paddr == `NOUN_REG_ROOTS);
  assign is_status = (paddr == `NOUN_REG_STATUS);
  assign is_visits = (paddr == `NOUN_REG_VISITS);
  assign node_off  = paddr - `NOUN_NODE_BASE;
  assign in_window = (paddr >= `NOUN_NODE_BASE) &&
                     (paddr < `NOUN_NODE_BASE + 4 * `NOUN_DEPTH) && (paddr[1:0] == 2'b00);

  // Node loads go straight to the store, blocked while the engine runs
  assign mem.wr_en   = wr_access && in_window && !busy;
  assign mem.wr_addr = node_off[`NOUN_FIELD_W+1:2];
  assign mem.wr_data = noun_eq_pkg::noun_word_t'(pwdata[`NOUN_WORD_W-1:0]);

  // A start while busy is dropped without an error
  assign start = wr_access && is_ctrl && pwdata[0] && !busy;

  assign pslverr = access && (!(is_ctrl || is_roots || is_status || is_visits || in_window) ||
                              (pwrite && busy && (is_roots || in_window)));

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      root_a <= '0;
      root_b <= '0;
    end else if (wr_access && is_roots && !busy) begin
      root_a <= pwdata[`NOUN_FIELD_W-1:0];
      root_b <= pwdata[2*`NOUN_FIELD_W-1:`NOUN_FIELD_W];
    end
  end

  always_comb begin
    prdata = '0;
    if (is_roots) begin
      prdata = {{(32 - 2 * `NOUN_FIELD_W){1'b0}}, root_b, root_a};
    end else if (is_status) begin
      prdata = {28'b0, verdict, done, busy};
    end else if (is_visits) begin
      prdata = {{(32 - VW){1'b0}}, visits};
    end
  end

endmodule

//--- verilog/eq_fsm.sv
`timescale 1ns/1ps
`include "noun_eq_params.svh"

module eq_fsm (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  logic [`NOUN_FIELD_W-1:0] root_a,
  input  logic [`NOUN_FIELD_W-1:0] root_b,
  node_mem_if.engine               mem,
  output logic                     push,
  output logic                     pop,
  output logic [`NOUN_FIELD_W-1:0] push_a,
  output logic [`NOUN_FIELD_W-1:0] push_b,
  input  logic [`NOUN_FIELD_W-1:0] top_a,
  input  logic [`NOUN_FIELD_W-1:0] top_b,
  input  logic                     empty,
  input  logic                     overflow,
  output logic                     count_en,
  output logic                     clear,
  input  logic                     limit_hit,
  output logic                     busy,
  output logic                     done,
  output noun_eq_pkg::verdict_e    verdict
);

  noun_eq_pkg::eq_state_e   state;
  noun_eq_pkg::eq_state_e   state_d;
  noun_eq_pkg::verdict_e    verdict_d;
  noun_eq_pkg::tag_pair_e   tags_a;
  noun_eq_pkg::tag_pair_e   tags_b;
  logic [`NOUN_FIELD_W-1:0] cur_a;
  logic [`NOUN_FIELD_W-1:0] cur_b;
  logic [`NOUN_FIELD_W-1:0] cur_a_d;
  logic [`NOUN_FIELD_W-1:0] cur_b_d;
  logic                     hed_eq;
  logic                     tel_eq;

  // Current pair is presented continuously, data lands in COMPARE
  assign mem.rd_addr_a = cur_a;
  assign mem.rd_addr_b = cur_b;

  assign tags_a = noun_eq_pkg::tag_pair_e'({mem.rd_data_a.hed_tag, mem.rd_data_a.tel_tag});
  assign tags_b = noun_eq_pkg::tag_pair_e'({mem.rd_data_b.hed_tag, mem.rd_data_b.tel_tag});
  assign hed_eq = (mem.rd_data_a.hed == mem.rd_data_b.hed);
  assign tel_eq = (mem.rd_data_a.tel == mem.rd_data_b.tel);

  // Tel pair is what gets deferred on a cell/cell node
  assign push_a = mem.rd_data_a.tel;
  assign push_b = mem.rd_data_b.tel;

  assign busy = (state == noun_eq_pkg::FETCH) || (state == noun_eq_pkg::COMPARE) ||
                (state == noun_eq_pkg::POP);
  assign done = (state == noun_eq_pkg::DONE);

  always_comb begin
    state_d   = state;
    verdict_d = verdict;
    cur_a_d   = cur_a;
    cur_b_d   = cur_b;
    push      = 1'b0;
    pop       = 1'b0;
    count_en  = 1'b0;
    clear     = 1'b0;
    case (state)
      noun_eq_pkg::IDLE, noun_eq_pkg::DONE: begin
        if (start) begin
          state_d   = noun_eq_pkg::FETCH;
          verdict_d = noun_eq_pkg::V_NONE;
          cur_a_d   = root_a;
          cur_b_d   = root_b;
          clear     = 1'b1;
        end
      end
      noun_eq_pkg::FETCH: begin
        state_d = noun_eq_pkg::COMPARE;
      end
      noun_eq_pkg::COMPARE: begin
        if (overflow || limit_hit) begin
          // Cyclic or too deep graph
          state_d   = noun_eq_pkg::DONE;
          verdict_d = noun_eq_pkg::V_ABORT;
        end else begin
          count_en  = 1'b1;
          state_d   = noun_eq_pkg::DONE;
          verdict_d = noun_eq_pkg::V_NOT_EQUAL;
          if (tags_a == tags_b) begin
            case (tags_a)
              noun_eq_pkg::ATOM_ATOM: begin
                if (hed_eq && tel_eq) begin
                  state_d   = noun_eq_pkg::POP;
                  verdict_d = verdict;
                end
              end
              noun_eq_pkg::ATOM_CELL: begin
                if (hed_eq) begin
                  state_d   = noun_eq_pkg::FETCH;
                  verdict_d = verdict;
                  cur_a_d   = mem.rd_data_a.tel;
                  cur_b_d   = mem.rd_data_b.tel;
                end
              end
              noun_eq_pkg::CELL_ATOM: begin
                if (tel_eq) begin
                  state_d   = noun_eq_pkg::FETCH;
                  verdict_d = verdict;
                  cur_a_d   = mem.rd_data_a.hed;
                  cur_b_d   = mem.rd_data_b.hed;
                end
              end
              default: begin
                // Descend into hed, tel pair waits on the stack
                push      = 1'b1;
                state_d   = noun_eq_pkg::FETCH;
                verdict_d = verdict;
                cur_a_d   = mem.rd_data_a.hed;
                cur_b_d   = mem.rd_data_b.hed;
              end
            endcase
          end
        end
      end
      noun_eq_pkg::POP: begin
        if (empty) begin
          state_d   = noun_eq_pkg::DONE;
          verdict_d = noun_eq_pkg::V_EQUAL;
        end else begin
          pop     = 1'b1;
          state_d = noun_eq_pkg::FETCH;
          cur_a_d = top_a;
          cur_b_d = top_b;
        end
      end
      default: begin
        state_d = noun_eq_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state   <= noun_eq_pkg::IDLE;
      verdict <= noun_eq_pkg::V_NONE;
    end else begin
      state   <= state_d;
      verdict <= verdict_d;
    end
  end

  always_ff @(posedge clk) begin
    cur_a <= cur_a_d;
    cur_b <= cur_b_d;
  end

endmodule

//--- verilog/node_mem_if.sv
`timescale 1ns/1ps
`include "noun_eq_params.svh"

interface node_mem_if;

  // Two read ports for the lockstep walk
  logic [`NOUN_FIELD_W-1:0] rd_addr_a;
  logic [`NOUN_FIELD_W-1:0] rd_addr_b;
  noun_eq_pkg::noun_word_t  rd_data_a;
  noun_eq_pkg::noun_word_t  rd_data_b;

  // Host load port
  logic                     wr_en;
  logic [`NOUN_FIELD_W-1:0] wr_addr;
  noun_eq_pkg::noun_word_t  wr_data;

  modport engine (
    output rd_addr_a, rd_addr_b,
    input  rd_data_a, rd_data_b
  );

  modport host (
    output wr_en, wr_addr, wr_data
  );

  modport store (
    input  rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
    output rd_data_a, rd_data_b
  );

endinterface

//--- verilog/noun_eq_params.svh
`ifndef NOUN_EQ_PARAMS_SVH
`define NOUN_EQ_PARAMS_SVH

// Node word layout: two tag bits then hed and tel fields
`define NOUN_FIELD_W 8
`define NOUN_WORD_W 18

// Storage sizes
`define NOUN_DEPTH 256
`define NOUN_STACK_DEPTH 16

// Node pairs compared before the engine gives up
`define NOUN_VISIT_LIMIT 1024

// APB register map, byte offsets
`define NOUN_APB_AW 12
`define NOUN_REG_CTRL 12'h000
`define NOUN_REG_ROOTS 12'h004
`define NOUN_REG_STATUS 12'h008
`define NOUN_REG_VISITS 12'h00C
`define NOUN_NODE_BASE 12'h400

`endif

//--- verilog/noun_eq_pkg.sv
`include "noun_eq_params.svh"

package noun_eq_pkg;

  // Tag bit is 1 for a cell (field is an address), 0 for an atom
  typedef struct packed {
    logic                     hed_tag;
    logic                     tel_tag;
    logic [`NOUN_FIELD_W-1:0] hed;
    logic [`NOUN_FIELD_W-1:0] tel;
  } noun_word_t;

  // Decoded as {hed_tag, tel_tag}
  typedef enum logic [1:0] {
    ATOM_ATOM = 2'b00,
    ATOM_CELL = 2'b01,
    CELL_ATOM = 2'b10,
    CELL_CELL = 2'b11
  } tag_pair_e;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    COMPARE,
    POP,
    DONE
  } eq_state_e;

  typedef enum logic [1:0] {
    V_NONE,
    V_EQUAL,
    V_NOT_EQUAL,
    V_ABORT
  } verdict_e;

endpackage

//--- verilog/noun_eq_top.sv
`timescale 1ns/1ps
`include "noun_eq_params.svh"

module noun_eq_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`NOUN_APB_AW-1:0] paddr,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr
);

  logic                                   start;
  logic [`NOUN_FIELD_W-1:0]               root_a;
  logic [`NOUN_FIELD_W-1:0]               root_b;
  logic                                   busy;
  logic                                   done;
  noun_eq_pkg::verdict_e                  verdict;
  logic [$clog2(`NOUN_VISIT_LIMIT+1)-1:0] visits;

  // Engine to stack and counter
  logic                                   push;
  logic                                   pop;
  logic [`NOUN_FIELD_W-1:0]               push_a;
  logic [`NOUN_FIELD_W-1:0]               push_b;
  logic [`NOUN_FIELD_W-1:0]               top_a;
  logic [`NOUN_FIELD_W-1:0]               top_b;
  logic                                   empty;
  logic                                   overflow;
  logic                                   count_en;
  logic                                   clear;
  logic                                   limit_hit;

  node_mem_if mem_bus ();

  apb_regs u_apb_regs (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .mem     (mem_bus.host),
    .start   (start),
    .root_a  (root_a),
    .root_b  (root_b),
    .busy    (busy),
    .done    (done),
    .verdict (verdict),
    .visits  (visits)
  );

  noun_store u_noun_store (
    .clk (clk),
    .mem (mem_bus.store)
  );

  eq_fsm u_eq_fsm (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .root_a    (root_a),
    .root_b    (root_b),
    .mem       (mem_bus.engine),
    .push      (push),
    .pop       (pop),
    .push_a    (push_a),
    .push_b    (push_b),
    .top_a     (top_a),
    .top_b     (top_b),
    .empty     (empty),
    .overflow  (overflow),
    .count_en  (count_en),
    .clear     (clear),
    .limit_hit (limit_hit),
    .busy      (busy),
    .done      (done),
    .verdict   (verdict)
  );

  pair_stack u_pair_stack (
    .clk      (clk),
    .rst      (rst),
    .clear    (clear),
    .push     (push),
    .pop      (pop),
    .push_a   (push_a),
    .push_b   (push_b),
    .top_a    (top_a),
    .top_b    (top_b),
    .empty    (empty),
    .overflow (overflow)
  );

  visit_counter u_visit_counter (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .count_en  (count_en),
    .visits    (visits),
    .limit_hit (limit_hit)
  );

endmodule

//--- verilog/noun_store.sv
`timescale 1ns/1ps
`include "noun_eq_params.svh"

module noun_store (
  input logic      clk,
  node_mem_if.store mem
);

  noun_eq_pkg::noun_word_t nodes [`NOUN_DEPTH];

  // Host write port
  always_ff @(posedge clk) begin
    if (mem.wr_en) begin
      nodes[mem.wr_addr] <= mem.wr_data;
    end
  end

  // Registered reads, data one cycle after the address
  always_ff @(posedge clk) begin
    mem.rd_data_a <= nodes[mem.rd_addr_a];
    mem.rd_data_b <= nodes[mem.rd_addr_b];
  end

endmodule

//--- verilog/pair_stack.sv
`timescale 1ns/1ps
`include "noun_eq_params.svh"

module pair_stack (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clear,
  input  logic                     push,
  input  logic                     pop,
  input  logic [`NOUN_FIELD_W-1:0] push_a,
  input  logic [`NOUN_FIELD_W-1:0] push_b,
  output logic [`NOUN_FIELD_W-1:0] top_a,
  output logic [`NOUN_FIELD_W-1:0] top_b,
  output logic                     empty,
  output logic                     overflow
);

  localparam int PW = $clog2(`NOUN_STACK_DEPTH);

  logic [`NOUN_FIELD_W-1:0] stack_a [`NOUN_STACK_DEPTH];
  logic [`NOUN_FIELD_W-1:0] stack_b [`NOUN_STACK_DEPTH];
  logic [PW:0]              sp;
  logic [PW-1:0]            top_idx;
  logic                     full;

  assign full    = (sp == `NOUN_STACK_DEPTH);
  assign empty   = (sp == '0);
  assign top_idx = sp[PW-1:0] - 1'b1;
  assign top_a   = stack_a[top_idx];
  assign top_b   = stack_b[top_idx];

  // Pointer and sticky overflow, both dropped by clear at start
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      sp       <= '0;
      overflow <= 1'b0;
    end else if (clear) begin
      sp       <= '0;
      overflow <= 1'b0;
    end else if (push) begin
      if (full) begin
        overflow <= 1'b1;
      end else begin
        sp <= sp + 1'b1;
      end
    end else if (pop && !empty) begin
      sp <= sp - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push && !full) begin
      stack_a[sp[PW-1:0]] <= push_a;
      stack_b[sp[PW-1:0]] <= push_b;
    end
  end

endmodule

//--- verilog/visit_counter.sv
`timescale 1ns/1ps
`include "noun_eq_params.svh"

module visit_counter (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   clear,
  input  logic                                   count_en,
  output logic [$clog2(`NOUN_VISIT_LIMIT+1)-1:0] visits,
  output logic                                   limit_hit
);

  assign limit_hit = (visits == `NOUN_VISIT_LIMIT);

  // Saturates at the limit
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      visits <= '0;
    end else if (clear) begin
      visits <= '0;
    end else if (count_en && !limit_hit) begin
      visits <= visits + 1'b1;
    end
  end

endmodule
